//--- lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define LSU_XLEN 32
`define LSU_TRANS_ID_W 3

// ------------------------------------------------------------
// request queue and scratchpad sizing
// ------------------------------------------------------------
// queue entries, also the credits handed out after reset
`define LSU_QUEUE_DEPTH 4
// 32-bit words, byte range 0 .. 4*words-1
`define LSU_MEM_WORDS 64

// output register stages per result stream
`define LSU_LOAD_PIPE_DEPTH 1
`define LSU_STORE_PIPE_DEPTH 2

`endif

//--- lsu_mem_pkg.sv
`include "lsu_defines.svh"

package lsu_mem_pkg;

    // riscv mcause numbering
    typedef enum logic [3:0] {
        CAUSE_LD_MISALIGNED = 4'd4,
        CAUSE_LD_ACCESS     = 4'd5,
        CAUSE_ST_MISALIGNED = 4'd6,
        CAUSE_ST_ACCESS     = 4'd7
    } ex_cause_e;

    typedef struct packed {
        logic                         valid;
        logic [`LSU_TRANS_ID_W-1:0]   trans_id;
        logic                         ex_valid;
        ex_cause_e                    ex_cause;
        logic [`LSU_XLEN-1:0]         ex_tval;
        logic [`LSU_XLEN-1:0]         data;
    } load_res_t;

    typedef struct packed {
        logic                         valid;
        logic [`LSU_TRANS_ID_W-1:0]   trans_id;
        logic                         ex_valid;
        ex_cause_e                    ex_cause;
        logic [`LSU_XLEN-1:0]         ex_tval;
    } store_res_t;

endpackage

//--- lsu_op_pkg.sv
`include "lsu_defines.svh"

package lsu_op_pkg;

    // bit 3 store, bit 2 unsigned, bits 1:0 size
    typedef enum logic [3:0] {
        LB  = 4'h0,
        LH  = 4'h1,
        LW  = 4'h2,
        LBU = 4'h4,
        LHU = 4'h5,
        SB  = 4'h8,
        SH  = 4'h9,
        SW  = 4'ha
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // decoded request as it sits in the queue
    typedef struct packed {
        lsu_op_e                      op;
        logic                         is_store;
        logic [`LSU_XLEN-1:0]         addr;
        logic [`LSU_XLEN-1:0]         wdata;    // already on its byte lanes
        logic [`LSU_XLEN/8-1:0]       be;
        logic [`LSU_TRANS_ID_W-1:0]   trans_id;
        logic                         ex_valid;
        lsu_mem_pkg::ex_cause_e       ex_cause;
    } lsu_req_t;

endpackage

//--- lsu_decode.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_decode (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        lsu_valid_i,
    input  lsu_op_pkg::lsu_op_e         lsu_op_i,
    input  logic [`LSU_XLEN-1:0]        operand_a_i,
    input  logic [`LSU_XLEN-1:0]        imm_i,
    input  logic [`LSU_XLEN-1:0]        store_data_i,
    input  logic [`LSU_TRANS_ID_W-1:0]  trans_id_i,
    output logic                        req_valid_o,
    output lsu_op_pkg::lsu_req_t        req_o
);

    logic [`LSU_XLEN-1:0]     vaddr;
    lsu_op_pkg::size_e        size;
    logic                     is_store;
    logic [`LSU_XLEN/8-1:0]   be;
    logic                     misaligned;
    logic                     out_of_range;
    lsu_mem_pkg::ex_cause_e   cause;

    // ------------------------------------------------------------
    // address generation
    // ------------------------------------------------------------
    // imm arrives sign extended, so a plain add wraps correctly
    assign vaddr = operand_a_i + imm_i;

    always_comb begin : op_decode
        case (lsu_op_i)
            lsu_op_pkg::LB, lsu_op_pkg::LBU, lsu_op_pkg::SB: size = lsu_op_pkg::SIZE_BYTE;
            lsu_op_pkg::LH, lsu_op_pkg::LHU, lsu_op_pkg::SH: size = lsu_op_pkg::SIZE_HALF;
            default:                                         size = lsu_op_pkg::SIZE_WORD;
        endcase
    end

    assign is_store = lsu_op_i inside {lsu_op_pkg::SB, lsu_op_pkg::SH, lsu_op_pkg::SW};

    // byte enables from the low address bits
    always_comb begin : be_gen
        case (size)
            lsu_op_pkg::SIZE_BYTE: be = 4'b0001 << vaddr[1:0];
            lsu_op_pkg::SIZE_HALF: be = 4'b0011 << vaddr[1:0];
            default:               be = 4'b1111;
        endcase
    end

    // ------------------------------------------------------------
    // exception checks
    // ------------------------------------------------------------
    assign misaligned = ((size == lsu_op_pkg::SIZE_HALF) && vaddr[0])
                     || ((size == lsu_op_pkg::SIZE_WORD) && (vaddr[1:0] != 2'b00));

    assign out_of_range = vaddr >= `LSU_XLEN'(4 * `LSU_MEM_WORDS);

    // misalignment wins over the range check
    always_comb begin : cause_sel
        if (misaligned) begin
            cause = is_store ? lsu_mem_pkg::CAUSE_ST_MISALIGNED
                             : lsu_mem_pkg::CAUSE_LD_MISALIGNED;
        end else begin
            cause = is_store ? lsu_mem_pkg::CAUSE_ST_ACCESS
                             : lsu_mem_pkg::CAUSE_LD_ACCESS;
        end
    end

    // ------------------------------------------------------------
    // request register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= lsu_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lsu_valid_i) begin
            req_o.op       <= lsu_op_i;
            req_o.is_store <= is_store;
            req_o.addr     <= vaddr;
            // store data moved onto its byte lanes
            req_o.wdata    <= store_data_i << {vaddr[1:0], 3'b000};
            req_o.be       <= be;
            req_o.trans_id <= trans_id_i;
            req_o.ex_valid <= misaligned | out_of_range;
            req_o.ex_cause <= cause;
        end
    end

    // sender must only issue known operation codes
    a_legal_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i |-> lsu_op_i inside {lsu_op_pkg::LB, lsu_op_pkg::LH, lsu_op_pkg::LW,
                                         lsu_op_pkg::LBU, lsu_op_pkg::LHU, lsu_op_pkg::SB,
                                         lsu_op_pkg::SH, lsu_op_pkg::SW})
        else $error("illegal lsu operation %0h", lsu_op_i);

endmodule

//--- lsu_execute.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_execute (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     req_valid_i,
    input  lsu_op_pkg::lsu_req_t     req_i,
    output logic                     credit_o,
    output lsu_mem_pkg::load_res_t   load_res_o,
    output lsu_mem_pkg::store_res_t  store_res_o
);

    localparam int unsigned ptr_w = $clog2(`LSU_QUEUE_DEPTH);
    localparam int unsigned cnt_w = $clog2(`LSU_QUEUE_DEPTH + 1);
    localparam int unsigned aw    = $clog2(`LSU_MEM_WORDS);

    lsu_op_pkg::lsu_req_t    queue_q [`LSU_QUEUE_DEPTH];
    logic [ptr_w-1:0]        wr_ptr_q;
    logic [ptr_w-1:0]        rd_ptr_q;
    logic [cnt_w-1:0]        count_q;
    logic [cnt_w-1:0]        count_d;
    logic                    pop;
    lsu_op_pkg::lsu_req_t    head;
    logic [aw-1:0]           head_waddr;

    logic [`LSU_XLEN-1:0]    mem_q [`LSU_MEM_WORDS];
    logic [`LSU_XLEN-1:0]    rdata_q;
    logic                    ret_valid_q;
    lsu_op_pkg::lsu_req_t    ret_q;
    logic [`LSU_XLEN-1:0]    lane;
    logic [`LSU_XLEN-1:0]    load_data;

    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(`LSU_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ------------------------------------------------------------
    // request queue, one retire per cycle while non-empty
    // ------------------------------------------------------------
    assign pop      = (count_q != '0);
    assign credit_o = pop;
    assign head     = queue_q[rd_ptr_q];
    assign head_waddr = head.addr[aw+1:2];

    always_comb begin
        count_d = count_q;
        if (req_valid_i && !pop) begin
            count_d = count_q + 1'b1;
        end else if (!req_valid_i && pop) begin
            count_d = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            ret_valid_q <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q     <= count_d;
            ret_valid_q <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            queue_q[wr_ptr_q] <= req_i;
        end
        if (pop) begin
            ret_q <= head;
        end
        // faulting loads never touch the scratchpad
        if (pop && !head.is_store && !head.ex_valid) begin
            rdata_q <= mem_q[head_waddr];
        end
    end

    // ------------------------------------------------------------
    // scratchpad, cleared on reset
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (pop && head.is_store && !head.ex_valid) begin
            for (int b = 0; b < `LSU_XLEN / 8; b++) begin
                if (head.be[b]) begin
                    mem_q[head_waddr][8*b +: 8] <= head.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // load lane select and extension
    // ------------------------------------------------------------
    always_comb begin : load_extend
        lane = rdata_q >> {ret_q.addr[1:0], 3'b000};
        case (ret_q.op)
            lsu_op_pkg::LB:  load_data = {{(`LSU_XLEN-8){lane[7]}}, lane[7:0]};
            lsu_op_pkg::LBU: load_data = {{(`LSU_XLEN-8){1'b0}}, lane[7:0]};
            lsu_op_pkg::LH:  load_data = {{(`LSU_XLEN-16){lane[15]}}, lane[15:0]};
            lsu_op_pkg::LHU: load_data = {{(`LSU_XLEN-16){1'b0}}, lane[15:0]};
            default:         load_data = lane;
        endcase
        if (ret_q.ex_valid) begin
            load_data = '0;
        end
    end

    assign load_res_o.valid    = ret_valid_q & ~ret_q.is_store;
    assign load_res_o.trans_id = ret_q.trans_id;
    assign load_res_o.ex_valid = ret_q.ex_valid;
    assign load_res_o.ex_cause = ret_q.ex_cause;
    assign load_res_o.ex_tval  = ret_q.ex_valid ? ret_q.addr : '0;
    assign load_res_o.data     = load_data;

    assign store_res_o.valid    = ret_valid_q & ret_q.is_store;
    assign store_res_o.trans_id = ret_q.trans_id;
    assign store_res_o.ex_valid = ret_q.ex_valid;
    assign store_res_o.ex_cause = ret_q.ex_cause;
    assign store_res_o.ex_tval  = ret_q.ex_valid ? ret_q.addr : '0;

    // credits at the sender keep the queue from overflowing
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> (count_q < cnt_w'(`LSU_QUEUE_DEPTH)))
        else $error("request written into a full queue");

    a_one_stream: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(load_res_o.valid && store_res_o.valid))
        else $error("load and store results in the same cycle");

endmodule

//--- lsu_result_pipe.sv
`timescale 1ns/1ps

module lsu_result_pipe #(
    parameter type         dtype = logic,
    parameter int unsigned depth = 1
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  dtype d_i,
    output dtype d_o
);

    dtype stage_q [depth];

    if (depth < 1) begin : gen_depth_check
        $error("lsu_result_pipe needs at least one stage");
    end

    // ------------------------------------------------------------
    // shift register, zero payload means not valid
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < depth; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign d_o = stage_q[depth-1];

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        lsu_valid_i,
    input  lsu_op_pkg::lsu_op_e         lsu_op_i,
    input  logic [`LSU_XLEN-1:0]        operand_a_i,
    input  logic [`LSU_XLEN-1:0]        imm_i,
    input  logic [`LSU_XLEN-1:0]        store_data_i,
    input  logic [`LSU_TRANS_ID_W-1:0]  trans_id_i,
    output logic                        credit_o,
    output logic                        load_valid_o,
    output logic [`LSU_TRANS_ID_W-1:0]  load_trans_id_o,
    output logic [`LSU_XLEN-1:0]        load_data_o,
    output logic                        load_ex_valid_o,
    output lsu_mem_pkg::ex_cause_e      load_ex_cause_o,
    output logic [`LSU_XLEN-1:0]        load_ex_tval_o,
    output logic                        store_valid_o,
    output logic [`LSU_TRANS_ID_W-1:0]  store_trans_id_o,
    output logic                        store_ex_valid_o,
    output lsu_mem_pkg::ex_cause_e      store_ex_cause_o,
    output logic [`LSU_XLEN-1:0]        store_ex_tval_o
);

    logic                     req_valid;
    lsu_op_pkg::lsu_req_t     req;
    lsu_mem_pkg::load_res_t   load_res;
    lsu_mem_pkg::store_res_t  store_res;
    lsu_mem_pkg::load_res_t   load_out;
    lsu_mem_pkg::store_res_t  store_out;

    lsu_decode u_decode (
        .clk_i, .rst_ni, .lsu_valid_i, .lsu_op_i,
        .operand_a_i, .imm_i, .store_data_i, .trans_id_i,
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    lsu_execute u_execute (
        .clk_i, .rst_ni, .credit_o,
        .req_valid_i (req_valid),
        .req_i       (req),
        .load_res_o  (load_res),
        .store_res_o (store_res)
    );

    // ------------------------------------------------------------
    // output pipelines, one per stream
    // ------------------------------------------------------------
    lsu_result_pipe #(
        .dtype (lsu_mem_pkg::load_res_t),
        .depth (`LSU_LOAD_PIPE_DEPTH)
    ) u_load_pipe (.clk_i, .rst_ni, .d_i (load_res), .d_o (load_out));

    lsu_result_pipe #(
        .dtype (lsu_mem_pkg::store_res_t),
        .depth (`LSU_STORE_PIPE_DEPTH)
    ) u_store_pipe (.clk_i, .rst_ni, .d_i (store_res), .d_o (store_out));

    assign load_valid_o     = load_out.valid;
    assign load_trans_id_o  = load_out.trans_id;
    assign load_data_o      = load_out.data;
    assign load_ex_valid_o  = load_out.ex_valid;
    assign load_ex_cause_o  = load_out.ex_cause;
    assign load_ex_tval_o   = load_out.ex_tval;
    assign store_valid_o    = store_out.valid;
    assign store_trans_id_o = store_out.trans_id;
    assign store_ex_valid_o = store_out.ex_valid;
    assign store_ex_cause_o = store_out.ex_cause;
    assign store_ex_tval_o  = store_out.ex_tval;

endmodule

//--- lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_checker (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        credit_i,
    input  logic                        load_valid_i,
    input  logic [`LSU_TRANS_ID_W-1:0]  load_trans_id_i,
    input  logic [`LSU_XLEN-1:0]        load_data_i,
    input  logic                        load_ex_valid_i,
    input  lsu_mem_pkg::ex_cause_e      load_ex_cause_i,
    input  logic [`LSU_XLEN-1:0]        load_ex_tval_i,
    input  logic                        store_valid_i,
    input  logic [`LSU_TRANS_ID_W-1:0]  store_trans_id_i,
    input  logic                        store_ex_valid_i,
    input  lsu_mem_pkg::ex_cause_e      store_ex_cause_i,
    input  logic [`LSU_XLEN-1:0]        store_ex_tval_i
);

    typedef struct packed {
        logic [`LSU_TRANS_ID_W-1:0]  tid;
        logic [`LSU_XLEN-1:0]        data;
        logic                        ex;
        logic [3:0]                  cause;
        logic [`LSU_XLEN-1:0]        tval;
    } exp_t;

    exp_t load_q[$];
    exp_t store_q[$];
    int   pass_count = 0;
    int   fail_count = 0;
    int   test_count = 0;
    int   credit_count = 0;

    task automatic push_load(input exp_t e);
        load_q.push_back(e);
    endtask

    task automatic push_store(input exp_t e);
        store_q.push_back(e);
    endtask

    function automatic int pending();
        return load_q.size() + store_q.size();
    endfunction

    function automatic bit same(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // ------------------------------------------------------------
    // one test per result event in stream order
    // ------------------------------------------------------------
    task automatic check_load();
        exp_t e;
        bit   ok;
        test_count++;
        if (load_q.size() == 0) begin
            $display("test %0d: load result with tid %0d arrived but none was expected",
                     test_count, load_trans_id_i);
            fail_count++;
        end else begin
            e  = load_q.pop_front();
            ok = same("load_trans_id_o", 32'(e.tid), 32'(load_trans_id_i));
            ok = ok & same("load_data_o", e.data, load_data_i);
            ok = ok & same("load_ex_valid_o", 32'(e.ex), 32'(load_ex_valid_i));
            ok = ok & same("load_ex_tval_o", e.tval, load_ex_tval_i);
            if (e.ex) begin
                ok = ok & same("load_ex_cause_o", 32'(e.cause), 32'(load_ex_cause_i));
            end
            $display("test %0d: load tid %0d %s", test_count, e.tid, ok ? "ok" : "error");
            if (ok) pass_count++;
            else fail_count++;
        end
    endtask

    task automatic check_store();
        exp_t e;
        bit   ok;
        test_count++;
        if (store_q.size() == 0) begin
            $display("test %0d: store result with tid %0d arrived but none was expected",
                     test_count, store_trans_id_i);
            fail_count++;
        end else begin
            e  = store_q.pop_front();
            ok = same("store_trans_id_o", 32'(e.tid), 32'(store_trans_id_i));
            ok = ok & same("store_ex_valid_o", 32'(e.ex), 32'(store_ex_valid_i));
            ok = ok & same("store_ex_tval_o", e.tval, store_ex_tval_i);
            if (e.ex) begin
                ok = ok & same("store_ex_cause_o", 32'(e.cause), 32'(store_ex_cause_i));
            end
            $display("test %0d: store tid %0d %s", test_count, e.tid, ok ? "ok" : "error");
            if (ok) pass_count++;
            else fail_count++;
        end
    endtask

    // every retired request hands back exactly one credit
    task automatic check_credits(input int sent);
        bit ok;
        test_count++;
        ok = same("credit_o", 32'(sent), 32'(credit_count));
        $display("test %0d: credits returned %0d of %0d %s", test_count, credit_count, sent,
                 ok ? "ok" : "error");
        if (ok) pass_count++;
        else fail_count++;
    endtask

    // outputs change on the rising edge, so look at them mid cycle
    always @(negedge clk_i) begin
        if (rst_ni && credit_i) credit_count++;
        if (rst_ni && load_valid_i) check_load();
        if (rst_ni && store_valid_i) check_store();
    end

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu;

    localparam int N_DIRECTED = 22;
    localparam int N_RANDOM   = 40;
    localparam int N_ROWS     = N_DIRECTED + N_RANDOM;
    localparam int LIMIT      = 40 * N_ROWS + 100;

    // expected result of one request
    typedef struct packed {
        logic [`LSU_TRANS_ID_W-1:0]  tid;
        logic [`LSU_XLEN-1:0]        data;
        logic                        ex;
        logic [3:0]                  cause;
        logic [`LSU_XLEN-1:0]        tval;
    } exp_t;

    logic                        clk_i = 1'b0;
    logic                        rst_ni;
    logic                        lsu_valid_i;
    lsu_op_pkg::lsu_op_e         lsu_op_i;
    logic [`LSU_XLEN-1:0]        operand_a_i, imm_i, store_data_i;
    logic [`LSU_TRANS_ID_W-1:0]  trans_id_i;
    logic                        credit_o;
    logic                        load_valid_o, load_ex_valid_o;
    logic [`LSU_TRANS_ID_W-1:0]  load_trans_id_o, store_trans_id_o;
    logic [`LSU_XLEN-1:0]        load_data_o, load_ex_tval_o, store_ex_tval_o;
    lsu_mem_pkg::ex_cause_e      load_ex_cause_o, store_ex_cause_o;
    logic                        store_valid_o, store_ex_valid_o;

    // stimulus and expected values
    lsu_op_pkg::lsu_op_e  t_op [N_ROWS];
    logic [31:0]          t_a [N_ROWS], t_imm [N_ROWS], t_sd [N_ROWS];
    logic                 t_store [N_ROWS];
    exp_t                 t_exp [N_ROWS];

    logic [7:0]  ref_mem [256];
    logic [31:0] lcg_state = 32'hb2ec;
    int          n_rows = 0;
    int          credits;
    int          cycles = 0;

    always #10 clk_i = ~clk_i;

    lsu_top DUT (.*);

    lsu_checker u_checker (
        .clk_i, .rst_ni,
        .credit_i (credit_o),
        .load_valid_i (load_valid_o), .load_trans_id_i (load_trans_id_o),
        .load_data_i (load_data_o), .load_ex_valid_i (load_ex_valid_o),
        .load_ex_cause_i (load_ex_cause_o), .load_ex_tval_i (load_ex_tval_o),
        .store_valid_i (store_valid_o), .store_trans_id_i (store_trans_id_o),
        .store_ex_valid_i (store_ex_valid_o), .store_ex_cause_i (store_ex_cause_o),
        .store_ex_tval_i (store_ex_tval_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte-level reference of the scratchpad
    function automatic logic [31:0] ref_load(input lsu_op_pkg::lsu_op_e op, input int addr);
        logic [31:0] w;
        w = {ref_mem[(addr + 3) % 256], ref_mem[(addr + 2) % 256],
             ref_mem[(addr + 1) % 256], ref_mem[addr]};
        case (op)
            lsu_op_pkg::LB:  return {{24{w[7]}}, w[7:0]};
            lsu_op_pkg::LBU: return {24'h0, w[7:0]};
            lsu_op_pkg::LH:  return {{16{w[15]}}, w[15:0]};
            lsu_op_pkg::LHU: return {16'h0, w[15:0]};
            default:         return w;
        endcase
    endfunction

    task automatic ref_store(input lsu_op_pkg::lsu_op_e op, input int addr,
                             input logic [31:0] d);
        int n;
        n = (op == lsu_op_pkg::SB) ? 1 : (op == lsu_op_pkg::SH) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            ref_mem[addr + b] = d[8*b +: 8];
        end
    endtask

    // data argument is ignored for stores and for rows with an exception
    task automatic add_row(input lsu_op_pkg::lsu_op_e op, input logic [31:0] a,
                           input logic [31:0] imm, input logic [31:0] sd,
                           input logic [31:0] data, input logic ex, input logic [3:0] cause);
        logic [31:0] addr;
        addr = a + imm;
        t_op[n_rows]    = op;
        t_a[n_rows]     = a;
        t_imm[n_rows]   = imm;
        t_sd[n_rows]    = sd;
        t_store[n_rows] = op inside {lsu_op_pkg::SB, lsu_op_pkg::SH, lsu_op_pkg::SW};
        t_exp[n_rows].tid   = 3'(n_rows);
        t_exp[n_rows].data  = (ex || t_store[n_rows]) ? 32'h0 : data;
        t_exp[n_rows].ex    = ex;
        t_exp[n_rows].cause = cause;
        t_exp[n_rows].tval  = ex ? addr : 32'h0;
        if (t_store[n_rows] && !ex) ref_store(op, int'(addr), sd);
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0]         r, off, base;
        lsu_op_pkg::lsu_op_e op;
        // ------------------------------------------------------------
        // directed rows
        // ------------------------------------------------------------
        add_row(lsu_op_pkg::SW,  32'h10,  32'h0,        32'hdeadbeef, 0, 0, 0);
        add_row(lsu_op_pkg::LW,  32'h20,  32'hfffffff0, 0, 32'hdeadbeef, 0, 0);
        add_row(lsu_op_pkg::SB,  32'h40,  32'h1,        32'h000000a5, 0, 0, 0);
        add_row(lsu_op_pkg::SH,  32'h40,  32'h2,        32'h00008123, 0, 0, 0);
        add_row(lsu_op_pkg::LB,  32'h41,  32'h0, 0, 32'hffffffa5, 0, 0);
        add_row(lsu_op_pkg::LBU, 32'h41,  32'h0, 0, 32'h000000a5, 0, 0);
        add_row(lsu_op_pkg::LH,  32'h42,  32'h0, 0, 32'hffff8123, 0, 0);
        add_row(lsu_op_pkg::LHU, 32'h42,  32'h0, 0, 32'h00008123, 0, 0);
        add_row(lsu_op_pkg::LW,  32'h40,  32'h0, 0, 32'h8123a500, 0, 0);
        // misaligned accesses leave the scratchpad untouched
        add_row(lsu_op_pkg::LH,  32'h11,  32'h0, 0, 0, 1, 4);
        add_row(lsu_op_pkg::LW,  32'h12,  32'h0, 0, 0, 1, 4);
        add_row(lsu_op_pkg::SH,  32'h10,  32'h1, 32'h0000ffff, 0, 1, 6);
        add_row(lsu_op_pkg::SW,  32'h12,  32'h0, 32'h12345678, 0, 1, 6);
        add_row(lsu_op_pkg::LW,  32'h10,  32'h0, 0, 32'hdeadbeef, 0, 0);
        // out of range accesses where misalignment wins when both apply
        add_row(lsu_op_pkg::LW,  32'h100, 32'h0,  0, 0, 1, 5);
        add_row(lsu_op_pkg::SB,  32'h1f0, 32'h20, 32'h77, 0, 1, 7);
        add_row(lsu_op_pkg::LH,  32'h101, 32'h0,  0, 0, 1, 4);
        add_row(lsu_op_pkg::SW,  32'h102, 32'h0,  32'h1, 0, 1, 6);
        // back to back burst
        add_row(lsu_op_pkg::SW,  32'h80,  32'h0, 32'h11111111, 0, 0, 0);
        add_row(lsu_op_pkg::SW,  32'h84,  32'h0, 32'h22222222, 0, 0, 0);
        add_row(lsu_op_pkg::LW,  32'h80,  32'h0, 0, 32'h11111111, 0, 0);
        add_row(lsu_op_pkg::LW,  32'h84,  32'h0, 0, 32'h22222222, 0, 0);
        // ------------------------------------------------------------
        // random aligned rows
        // ------------------------------------------------------------
        for (int i = 0; i < N_RANDOM; i++) begin
            r = lcg_next();
            // upper bits, the low bits of this generator repeat quickly
            case (r[30:28])
                3'd0: op = lsu_op_pkg::LB;
                3'd1: op = lsu_op_pkg::LBU;
                3'd2: op = lsu_op_pkg::LH;
                3'd3: op = lsu_op_pkg::LHU;
                3'd4: op = lsu_op_pkg::LW;
                3'd5: op = lsu_op_pkg::SB;
                3'd6: op = lsu_op_pkg::SH;
                default: op = lsu_op_pkg::SW;
            endcase
            base = {24'h0, r[15:8]};
            if (op inside {lsu_op_pkg::LH, lsu_op_pkg::LHU, lsu_op_pkg::SH}) base[0] = 1'b0;
            if (op inside {lsu_op_pkg::LW, lsu_op_pkg::SW}) base[1:0] = 2'b00;
            off = {24'h0, r[23:16]};
            add_row(op, base + off, -off, lcg_next(), ref_load(op, int'(base)), 0, 0);
        end
    endtask

    // credits come back on credit_o and go out with each request
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits <= `LSU_QUEUE_DEPTH;
        end else begin
            credits <= credits + (credit_o ? 1 : 0) - (lsu_valid_i ? 1 : 0);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, %0d results still missing",
                     cycles, u_checker.pending());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rst_ni       = 1'b0;
        lsu_valid_i  = 1'b0;
        lsu_op_i     = lsu_op_pkg::LW;
        operand_a_i  = '0;
        imm_i        = '0;
        store_data_i = '0;
        trans_id_i   = '0;
        for (int i = 0; i < 256; i++) ref_mem[i] = 8'h00;
        build_table();
        repeat (3) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk_i);
            #2;
            while (credits == 0) begin
                lsu_valid_i = 1'b0;
                @(posedge clk_i);
                #2;
            end
            lsu_op_i     = t_op[i];
            operand_a_i  = t_a[i];
            imm_i        = t_imm[i];
            store_data_i = t_sd[i];
            trans_id_i   = 3'(i);
            lsu_valid_i  = 1'b1;
            if (t_store[i]) u_checker.push_store(t_exp[i]);
            else u_checker.push_load(t_exp[i]);
        end
        @(posedge clk_i);
        #2 lsu_valid_i = 1'b0;
        while (u_checker.pending() != 0) @(posedge clk_i);
        repeat (5) @(posedge clk_i);
        u_checker.check_credits(n_rows);
        $display("passed %0d failed %0d", u_checker.pass_count, u_checker.fail_count);
        if (u_checker.fail_count == 0 && u_checker.pass_count == n_rows + 1) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
lsu_mem_pkg.sv
lsu_op_pkg.sv
lsu_decode.sv
lsu_execute.sv
lsu_result_pipe.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

//--- Makefile
TOP = tb_lsu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f
	verilator --lint-only --top-module lsu_top +incdir+. lsu_mem_pkg.sv lsu_op_pkg.sv \
		lsu_decode.sv lsu_execute.sv lsu_result_pipe.sv lsu_top.sv

clean:
	rm -rf obj_dir sim.log
